// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -j 0
TOP       = tb_sysz80
FILELIST  = src.f
OBJ_DIR   = obj_dir
PASS_MSG  = Simulation completed successfully

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: compile
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)

// ==== dv/sysz80_chk.sv ====
`timescale 1ns/1ps

module sysz80_chk (
    input logic              clk,
    input logic              rst_n,
    input bus_pkg::cpu_bus_t bus,
    input logic              wait_n
);

    // Failed assertion count
    int n_err = 0;

    // A cycle is either a read or a write, never both
    rd_wr_exclusive: assert property (
        @(posedge clk) disable iff (!rst_n)
        !(!bus.rd_n && !bus.wr_n)
    ) else begin
        $error("rd_n and wr_n low together");
        n_err++;
    end

    // Every strobe comes with a memory request
    strobe_has_mreq: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!bus.rd_n || !bus.wr_n) |-> !bus.mreq_n
    ) else begin
        $error("rd_n or wr_n low without mreq_n");
        n_err++;
    end

    // Wait states freeze address and strobes
    stable_in_wait: assert property (
        @(posedge clk) disable iff (!rst_n)
        (!wait_n && $past(!wait_n)) |->
            $stable({bus.addr, bus.m1_n, bus.mreq_n, bus.rd_n, bus.wr_n})
    ) else begin
        $error("bus moved while wait_n was low");
        n_err++;
    end

    // M1 marks opcode reads only
    m1_is_read: assert property (
        @(posedge clk) disable iff (!rst_n)
        !bus.m1_n |-> !bus.rd_n
    ) else begin
        $error("m1_n low without rd_n");
        n_err++;
    end

endmodule

// wait_n is the internal net of the top between the gate and the core
bind sysz80_top sysz80_chk u_chk (
    .clk    ( clk     ),
    .rst_n  ( rst_n   ),
    .bus    ( cpu_bus ),
    .wait_n ( wait_n  )
);

// ==== dv/tb_sysz80.sv ====
`timescale 1ns/1ps

module tb_sysz80;

    localparam int T_RESET = 0;
    localparam int T_ALU   = 1;
    localparam int T_RAM   = 2;
    localparam int T_JUMP  = 3;
    localparam int T_WAIT  = 4;
    localparam int T_HALT  = 5;

    logic              clk;
    logic              rst_n;
    logic              cen;
    logic [7:0]        cpu_din;
    logic              ram_cs;
    logic              rom_cs;
    logic              rom_ok;
    logic              cpu_cen;
    bus_pkg::cpu_bus_t cpu_bus;
    logic              halt_n;
    logic [7:0]        ram_dout;

    logic [7:0]  rom [0:32767];
    logic [7:0]  shadow [0:4095];
    logic [15:0] lfsr;
    logic        rom_req;
    logic        prev_m1;
    int          cnt;
    int          lat;
    int          next_lat;
    logic [15:0] epc;
    logic [7:0]  m_acc;
    logic        m_z;
    logic        m_c;
    int          n_instr;
    int          wd_limit;
    int          n_pass;
    int          n_fail;
    int          rem [6];
    int          errs [6];
    string       test_name [6] = '{"reset", "alu", "ram", "jump", "wait", "halt"};
    logic [15:0] fetch_addr_q [$];
    int          fetch_test_q [$];
    logic [15:0] write_addr_q [$];
    logic [7:0]  write_data_q [$];
    int          write_test_q [$];

    sysz80_top #(.RAM_AW(12), .RESET_PC(16'h0000)) UUT (
        .clk      ( clk      ),
        .rst_n    ( rst_n    ),
        .cen      ( cen      ),
        .cpu_din  ( cpu_din  ),
        .ram_cs   ( ram_cs   ),
        .rom_cs   ( rom_cs   ),
        .rom_ok   ( rom_ok   ),
        .cpu_cen  ( cpu_cen  ),
        .cpu_bus  ( cpu_bus  ),
        .halt_n   ( halt_n   ),
        .ram_dout ( ram_dout )
    );

    // Galois LFSR, taps 16,14,13,11
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        return s[0] ? ((s >> 1) ^ 16'hB400) : (s >> 1);
    endfunction

    // Three bits per draw, folded to 0..5 clks
    task draw_latency(output int v);
        logic [2:0] bits;
        bits = 3'd0;
        for (int i = 0; i < 3; i++) begin
            lfsr = lfsr_next(lfsr);
            bits = {bits[1:0], lfsr[0]};
        end
        v = int'(bits) % 6;
    endtask

    // Z80 immediate ALU rules, returns {z, c, result}
    function automatic logic [9:0] alu_model(input logic [2:0] op, input logic [7:0] a,
                                             input logic [7:0] b, input logic cin);
        int         full;
        logic [7:0] r;
        logic       z;
        logic       c;
        // Plain integer arithmetic, carry is going past 255 or below 0
        case (op)
            3'd0:    full = int'(a) + int'(b);
            3'd1:    full = int'(a) + int'(b) + int'(cin);
            3'd2:    full = int'(a) - int'(b);
            3'd3:    full = int'(a) - int'(b) - int'(cin);
            3'd4:    full = int'(a & b);
            3'd5:    full = int'(a ^ b);
            3'd6:    full = int'(a | b);
            default: full = 0;
        endcase
        if (op == 3'd7) begin
            // Compare keeps A, Z on equal, C when n is larger
            r = a;
            z = (a == b);
            c = (a < b);
        end else begin
            r = 8'(full);
            z = (r == 8'd0);
            c = (full > 255) || (full < 0);
        end
        return {z, c, r};
    endfunction

    // Program builder, tracks the expected A, flags and RAM alongside
    task emit(input logic [7:0] b);
        rom[epc[14:0]] = b;
        epc = epc + 16'd1;
    endtask

    task expect_fetch(input int t);
        fetch_addr_q.push_back(epc);
        fetch_test_q.push_back(t);
        rem[t]++;
        n_instr++;
    endtask

    task put_ld_imm(input int t, input logic [7:0] n);
        expect_fetch(t);
        emit(8'h3E);
        emit(n);
        m_acc = n;
    endtask

    task put_alu(input int t, input logic [2:0] op, input logic [7:0] n);
        logic [9:0] r;
        expect_fetch(t);
        emit({2'b11, op, 3'b110});
        emit(n);
        r = alu_model(op, m_acc, n, m_c);
        m_acc = r[7:0];
        m_c = r[8];
        m_z = r[9];
    endtask

    task put_store(input int t, input logic [15:0] a);
        expect_fetch(t);
        emit(8'h32);
        emit(a[7:0]);
        emit(a[15:8]);
        write_addr_q.push_back(a);
        write_data_q.push_back(m_acc);
        write_test_q.push_back(t);
        rem[t]++;
        shadow[a[11:0]] = m_acc;
    endtask

    task put_load(input int t, input logic [15:0] a);
        expect_fetch(t);
        emit(8'h3A);
        emit(a[7:0]);
        emit(a[15:8]);
        m_acc = shadow[a[11:0]];
    endtask

    // cond 0 always, 1 Z, 2 NZ
    // Taken jumps skip two filler bytes, untaken ones point into unused ROM
    task put_jump(input int t, input int cond);
        logic        taken;
        logic [15:0] target;
        taken = (cond == 0) || (cond == 1 && m_z) || (cond == 2 && !m_z);
        target = taken ? epc + 16'd5 : 16'h6000;
        expect_fetch(t);
        emit((cond == 0) ? 8'hC3 : ((cond == 1) ? 8'hCA : 8'hC2));
        emit(target[7:0]);
        emit(target[15:8]);
        if (taken) begin
            epc = target;
        end
    endtask

    task put_raw(input int t, input logic [7:0] b);
        expect_fetch(t);
        emit(b);
    endtask

    task build_program;
        for (int i = 0; i < 32768; i++) begin
            rom[i] = 8'(i) ^ 8'(i >> 7);
        end
        for (int i = 0; i < 4096; i++) begin
            shadow[i] = 8'h00;
        end
        // Eight ALU ops, each result stored
        put_ld_imm(T_ALU, 8'h3C);
        put_alu(T_ALU, 3'd0, 8'hF0);
        put_store(T_ALU, 16'hC000);
        put_alu(T_ALU, 3'd1, 8'h10);
        put_store(T_ALU, 16'hC001);
        put_alu(T_ALU, 3'd2, 8'h50);
        put_store(T_ALU, 16'hC002);
        put_alu(T_ALU, 3'd3, 8'h0D);
        put_store(T_ALU, 16'hC003);
        put_alu(T_ALU, 3'd4, 8'h5A);
        put_store(T_ALU, 16'hC004);
        put_alu(T_ALU, 3'd5, 8'hFF);
        put_store(T_ALU, 16'hC005);
        put_alu(T_ALU, 3'd6, 8'h81);
        put_store(T_ALU, 16'hC006);
        put_alu(T_ALU, 3'd7, 8'h5A);
        put_store(T_ALU, 16'hC007);
        // Store, clobber A, load back, store elsewhere
        put_ld_imm(T_RAM, 8'hA7);
        put_store(T_RAM, 16'hC100);
        put_ld_imm(T_RAM, 8'h00);
        put_load(T_RAM, 16'hC100);
        put_store(T_RAM, 16'hC101);
        // Equal compare then unequal compare
        put_ld_imm(T_JUMP, 8'h42);
        put_alu(T_JUMP, 3'd7, 8'h42);
        put_jump(T_JUMP, 1);
        put_jump(T_JUMP, 2);
        put_alu(T_JUMP, 3'd7, 8'h43);
        put_jump(T_JUMP, 2);
        put_jump(T_JUMP, 1);
        put_jump(T_JUMP, 0);
        // Mixed traffic, all under random ROM latency
        put_load(T_WAIT, 16'hC003);
        put_store(T_WAIT, 16'hC200);
        put_alu(T_WAIT, 3'd0, 8'h01);
        put_store(T_WAIT, 16'hC201);
        put_raw(T_WAIT, 8'h00);
        put_raw(T_WAIT, 8'h47);
        put_store(T_WAIT, 16'hC202);
        put_raw(T_HALT, 8'h76);
        // Final queue check after HALT
        rem[T_HALT]++;
    endtask

    task finish_check(input int t);
        rem[t]--;
        if (rem[t] == 0) begin
            $display("test %-6s %s (%0d errors)", test_name[t],
                     (errs[t] == 0) ? "ok" : "FAILED", errs[t]);
        end
    endtask

    task note_fail(input int t);
        errs[t]++;
        n_fail++;
    endtask

    task check_fetch(input logic [15:0] a);
        logic [15:0] exp_a;
        int          t;
        if (fetch_addr_q.size() == 0) begin
            $display("unexpected opcode fetch at address %h", a);
            note_fail(T_HALT);
        end else begin
            exp_a = fetch_addr_q.pop_front();
            t = fetch_test_q.pop_front();
            // The very first fetch belongs to the reset test
            if (t == T_ALU && rem[T_RESET] > 0) begin
                t = T_RESET;
                rem[T_ALU]--;
            end
            assert (a == exp_a) n_pass++;
            else begin
                $display("error: %s fetch expected %h actual %h", test_name[t], exp_a, a);
                note_fail(t);
            end
            finish_check(t);
        end
    endtask

    task check_write(input logic [15:0] a, input logic [7:0] d);
        int t;
        if (write_addr_q.size() == 0) begin
            $display("unexpected write of %h to address %h", d, a);
            note_fail(T_HALT);
        end else begin
            t = write_test_q.pop_front();
            assert (a == write_addr_q[0]) n_pass++;
            else begin
                $display("error: %s write address expected %h actual %h", test_name[t],
                         write_addr_q[0], a);
                note_fail(t);
            end
            assert (d == write_data_q[0]) n_pass++;
            else begin
                $display("error: %s write data expected %h actual %h", test_name[t],
                         write_data_q[0], d);
                note_fail(t);
            end
            void'(write_addr_q.pop_front());
            void'(write_data_q.pop_front());
            finish_check(t);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Memory map decode and ROM model with random ready latency
    assign rom_req = !cpu_bus.mreq_n && !cpu_bus.rd_n && (cpu_bus.addr < 16'h8000);

    always @(posedge clk) begin
        cen <= !cen;
        rom_cs <= rom_req;
        ram_cs <= !cpu_bus.mreq_n && (cpu_bus.addr >= 16'hC000);
        if (!rom_req) begin
            cnt <= 0;
            rom_ok <= 1'b0;
        end else if (!rom_ok) begin
            if (cnt == lat) begin
                rom_ok <= 1'b1;
            end else begin
                cnt <= cnt + 1;
            end
        end
        // ROM data only once ready, junk before
        if (rom_req) begin
            cpu_din <= (rom_ok || cnt == lat) ? rom[cpu_bus.addr[14:0]] : 8'hFF;
        end else if (cpu_bus.addr >= 16'hC000) begin
            cpu_din <= ram_dout;
        end else begin
            cpu_din <= 8'h00;
        end
        // New latency for the next access
        if (rom_cs && !rom_req) begin
            draw_latency(next_lat);
            lat <= next_lat;
        end
    end

    // Bus monitors
    always @(posedge clk) begin
        prev_m1 <= cpu_bus.m1_n;
        if (rst_n) begin
            if (prev_m1 && !cpu_bus.m1_n) begin
                check_fetch(cpu_bus.addr);
            end
            if (cen && !cpu_bus.wr_n && !cpu_bus.mreq_n) begin
                check_write(cpu_bus.addr, cpu_bus.dout);
            end
            assert (halt_n || cpu_bus.m1_n)
            else begin
                $display("opcode fetch started after HALT at address %h", cpu_bus.addr);
                note_fail(T_HALT);
            end
            // Clock enable goes back out unchanged
            assert (cpu_cen == cen)
            else begin
                $display("error: %s cpu_cen expected %b actual %b", test_name[T_HALT],
                         cen, cpu_cen);
                note_fail(T_HALT);
            end
        end
    end

    // Watchdog, worst case bus cycles per instruction plus margin
    initial begin
        #1;
        #(wd_limit);
        $display("timeout: the CPU did not reach HALT in time");
        $display("Simulation failed");
        $finish;
    end

    initial begin
        rst_n = 1'b0;
        cen = 1'b0;
        cpu_din = 8'h00;
        ram_cs = 1'b0;
        rom_cs = 1'b0;
        rom_ok = 1'b0;
        prev_m1 = 1'b1;
        cnt = 0;
        lfsr = 16'd47;
        epc = 16'h0000;
        m_acc = 8'h00;
        m_z = 1'b0;
        m_c = 1'b0;
        n_instr = 0;
        n_pass = 0;
        n_fail = 0;
        for (int i = 0; i < 6; i++) begin
            rem[i] = 0;
            errs[i] = 0;
        end
        // Idle strobes after reset and the first fetch address
        rem[T_RESET] = 2;
        build_program();
        draw_latency(lat);
        wd_limit = (n_instr * 3 * (3 + 5) * 2 + 16 + 1000) * 100;

        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(posedge clk);
        assert (cpu_bus.m1_n && cpu_bus.mreq_n && cpu_bus.rd_n && cpu_bus.wr_n && halt_n)
            n_pass++;
        else begin
            $display("strobes or halt_n not idle after reset");
            note_fail(T_RESET);
        end
        finish_check(T_RESET);

        wait (!halt_n);
        repeat (100) @(posedge clk);
        assert (fetch_addr_q.size() == 0 && write_addr_q.size() == 0) n_pass++;
        else begin
            $display("%0d fetches and %0d writes never happened", fetch_addr_q.size(),
                     write_addr_q.size());
            note_fail(T_HALT);
        end
        finish_check(T_HALT);

        // Bus protocol assertions of the bound checker
        n_fail = n_fail + UUT.u_chk.n_err;
        $display("checks: %0d passed, %0d failed", n_pass, n_fail);
        if (n_fail == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== source/alu_execute.sv ====
`timescale 1ns/1ps

module alu_execute (
    input  isa_pkg::dec_op_t op,
    input  logic [7:0]       acc,
    input  logic [7:0]       operand,
    input  isa_pkg::flags_t  flags,
    output logic [7:0]       result,
    output isa_pkg::flags_t  flags_next,
    output logic             cond_true
);
    import isa_pkg::*;

    // Bit 8 is carry for adds and borrow for subtracts
    logic [8:0] sum;

    always_comb begin
        case (op.alu)
            ALU_ADD: sum = {1'b0, acc} + {1'b0, operand};
            ALU_ADC: sum = {1'b0, acc} + {1'b0, operand} + {8'd0, flags.c};
            ALU_SUB: sum = {1'b0, acc} - {1'b0, operand};
            ALU_SBC: sum = {1'b0, acc} - {1'b0, operand} - {8'd0, flags.c};
            // Logic ops clear carry
            ALU_AND: sum = {1'b0, acc & operand};
            ALU_XOR: sum = {1'b0, acc ^ operand};
            ALU_OR:  sum = {1'b0, acc | operand};
            default: sum = {1'b0, acc} - {1'b0, operand};
        endcase

        // CP only compares, A keeps its value
        result       = (op.alu == ALU_CP) ? acc : sum[7:0];
        flags_next.z = (sum[7:0] == 8'd0);
        flags_next.c = sum[8];
    end

    // Jump test uses Z as left by the last ALU op
    always_comb begin
        case (op.cond)
            JC_ALWAYS: cond_true = 1'b1;
            JC_Z:      cond_true = flags.z;
            JC_NZ:     cond_true = !flags.z;
            default:   cond_true = 1'b0;
        endcase
    end

endmodule

// ==== source/bus_pkg.sv ====
package bus_pkg;

    // CPU side of the memory bus, as driven by the core
    // Strobes are active low like a real Z80
    typedef struct packed {
        // Memory address of the current machine cycle
        logic [15:0] addr;
        // Write data, valid from T1 of a write cycle
        logic [7:0]  dout;
        // Opcode fetch marker
        logic        m1_n;
        // Memory request
        logic        mreq_n;
        // Read strobe
        logic        rd_n;
        // Write strobe
        logic        wr_n;
    } cpu_bus_t;

    // ROM status from the external memory controller
    typedef struct packed {
        // Address decoder selects the ROM
        logic cs;
        // ROM data on cpu_din is valid
        logic ok;
    } rom_stat_t;

endpackage

// ==== source/isa_pkg.sv ====
package isa_pkg;

    // Whole opcodes matched through the raw view
    localparam logic [7:0] OPC_NOP    = 8'h00;
    localparam logic [7:0] OPC_LD_A_N = 8'h3E;
    localparam logic [7:0] OPC_LD_A_M = 8'h3A;
    localparam logic [7:0] OPC_LD_M_A = 8'h32;
    localparam logic [7:0] OPC_JP     = 8'hC3;
    localparam logic [7:0] OPC_JP_Z   = 8'hCA;
    localparam logic [7:0] OPC_JP_NZ  = 8'hC2;
    localparam logic [7:0] OPC_HALT   = 8'h76;

    // One opcode byte, seen whole or split into the x/y/z fields
    typedef union packed {
        logic [7:0] raw;
        struct packed {
            logic [1:0] x;
            logic [2:0] y;
            logic [2:0] z;
        } fld;
    } opcode_u;

    // Order follows the y field of the immediate ALU group
    typedef enum logic [2:0] {
        ALU_ADD, ALU_ADC, ALU_SUB, ALU_SBC,
        ALU_AND, ALU_XOR, ALU_OR,  ALU_CP
    } alu_op_e;

    typedef enum logic [2:0] {
        OP_NOP, OP_LD_IMM, OP_ALU_IMM, OP_LD_MEM,
        OP_ST_MEM, OP_JUMP, OP_HALT
    } op_kind_e;

    typedef enum logic [1:0] {
        JC_ALWAYS, JC_Z, JC_NZ
    } jump_cond_e;

    // What the sequencer and datapath need from one opcode
    typedef struct packed {
        op_kind_e   kind;
        alu_op_e    alu;
        jump_cond_e cond;
        // Operand bytes after the opcode, 0 to 2
        logic [1:0] n_opnd;
    } dec_op_t;

    // Only zero and carry are kept
    typedef struct packed {
        logic z;
        logic c;
    } flags_t;

endpackage

// ==== source/op_decode.sv ====
`timescale 1ns/1ps

module op_decode (
    input  isa_pkg::opcode_u opcode,
    output isa_pkg::dec_op_t op
);
    import isa_pkg::*;

    always_comb begin
        // Anything not listed runs as a one byte NOP
        op = '{kind: OP_NOP, alu: ALU_ADD, cond: JC_ALWAYS, n_opnd: 2'd0};

        // Immediate ALU group is 11 yyy 110, y picks the operation
        if (opcode.fld.x == 2'd3 && opcode.fld.z == 3'd6) begin
            op.kind   = OP_ALU_IMM;
            op.alu    = alu_op_e'(opcode.fld.y);
            op.n_opnd = 2'd1;
        end else begin
            case (opcode.raw)
                OPC_LD_A_N: begin
                    op.kind   = OP_LD_IMM;
                    op.n_opnd = 2'd1;
                end
                OPC_LD_A_M: begin
                    op.kind   = OP_LD_MEM;
                    op.n_opnd = 2'd2;
                end
                OPC_LD_M_A: begin
                    op.kind   = OP_ST_MEM;
                    op.n_opnd = 2'd2;
                end
                OPC_JP, OPC_JP_Z, OPC_JP_NZ: begin
                    op.kind   = OP_JUMP;
                    op.n_opnd = 2'd2;
                    if (opcode.raw == OPC_JP_Z) begin
                        op.cond = JC_Z;
                    end else if (opcode.raw == OPC_JP_NZ) begin
                        op.cond = JC_NZ;
                    end
                end
                OPC_HALT: op.kind = OP_HALT;
                // Explicit NOP keeps the default
                OPC_NOP:  op.kind = OP_NOP;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/result_writeback.sv ====
`timescale 1ns/1ps

module result_writeback (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             commit,
    input  isa_pkg::dec_op_t op,
    input  logic [7:0]       result,
    input  logic [7:0]       load_data,
    input  isa_pkg::flags_t  flags_next,
    output logic [7:0]       acc,
    output isa_pkg::flags_t  flags
);
    import isa_pkg::*;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            acc   <= 8'd0;
            flags <= '0;
        end else if (commit) begin
            case (op.kind)
                // Flags only move on ALU ops
                OP_ALU_IMM: begin
                    acc   <= result;
                    flags <= flags_next;
                end
                OP_LD_IMM, OP_LD_MEM: acc <= load_data;
                default: ;
            endcase
        end
    end

endmodule

// ==== source/rom_wait_gate.sv ====
`timescale 1ns/1ps

module rom_wait_gate (
    input  logic               clk,
    input  logic               rst_n,
    input  bus_pkg::rom_stat_t rom,
    output logic               wait_n
);

    // Previous rom_cs, so the first clk of a request can be told apart
    logic cs_q;
    // A fresh rom_ok arrived for the current request
    logic ok_seen;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cs_q    <= 1'b0;
            ok_seen <= 1'b0;
        end else begin
            cs_q <= rom.cs;
            // Request over, forget the old ready
            if (!rom.cs) begin
                ok_seen <= 1'b0;
            end else if (cs_q && rom.ok) begin
                // rom_ok in the rising clk of cs may be left from the last access
                ok_seen <= 1'b1;
            end
        end
    end

    // Low from the clk rom_cs rises until one clk after a fresh rom_ok
    assign wait_n = !(rom.cs && !ok_seen);

endmodule

// ==== source/sysz80_top.sv ====
`timescale 1ns/1ps

module sysz80_top #(
    parameter int          RAM_AW   = 12,
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic [7:0]        cpu_din,
    input  logic              ram_cs,
    input  logic              rom_cs,
    input  logic              rom_ok,
    output logic              cpu_cen,
    output bus_pkg::cpu_bus_t cpu_bus,
    output logic              halt_n,
    output logic [7:0]        ram_dout
);
    import bus_pkg::*;

    rom_stat_t rom_st;
    logic      wait_n;

    // CPU and RAM share the incoming clock enable
    assign cpu_cen = cen;
    assign rom_st  = '{cs: rom_cs, ok: rom_ok};

    // Holds the CPU in T2 until ROM data is really there
    rom_wait_gate u_wait (
        .clk    ( clk    ),
        .rst_n  ( rst_n  ),
        .rom    ( rom_st ),
        .wait_n ( wait_n )
    );

    z80_lite #(.RESET_PC(RESET_PC)) u_cpu (
        .clk    ( clk     ),
        .rst_n  ( rst_n   ),
        .cen    ( cen     ),
        .wait_n ( wait_n  ),
        .din    ( cpu_din ),
        .bus    ( cpu_bus ),
        .halt_n ( halt_n  )
    );

    work_ram #(.RAM_AW(RAM_AW)) u_ram (
        .clk    ( clk      ),
        .cen    ( cpu_cen  ),
        .bus    ( cpu_bus  ),
        .ram_cs ( ram_cs   ),
        .q      ( ram_dout )
    );

endmodule

// ==== source/work_ram.sv ====
`timescale 1ns/1ps

module work_ram #(
    parameter int RAM_AW = 12
) (
    input  logic              clk,
    input  logic              cen,
    input  bus_pkg::cpu_bus_t bus,
    input  logic              ram_cs,
    output logic [7:0]        q
);

    logic [7:0]        mem [0:(1 << RAM_AW) - 1];
    // Upper address bits are decoded outside through ram_cs
    logic [RAM_AW-1:0] addr;

    assign addr = bus.addr[RAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (cen) begin
            // wr_n is only low in T2, so one write per cycle
            if (ram_cs && !bus.wr_n) begin
                mem[addr] <= bus.dout;
            end
            q <= mem[addr];
        end
    end

endmodule

// ==== source/z80_lite.sv ====
`timescale 1ns/1ps

module z80_lite #(
    parameter logic [15:0] RESET_PC = 16'h0000
) (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              cen,
    input  logic              wait_n,
    input  logic [7:0]        din,
    output bus_pkg::cpu_bus_t bus,
    output logic              halt_n
);
    import isa_pkg::*;

    // Machine cycle kinds
    typedef enum logic [2:0] {
        MC_FETCH, MC_OPND1, MC_OPND2, MC_MEMRD, MC_MEMWR
    } mcycle_e;

    // T-states, idle after reset and once halted
    typedef enum logic [1:0] {
        TS_IDLE, TS_T1, TS_T2, TS_T3
    } tstate_e;

    logic        rst_sync;
    mcycle_e     mc;
    mcycle_e     next_mc;
    tstate_e     ts;
    logic        halted;
    logic [15:0] pc;
    opcode_u     opcode;
    logic [7:0]  opnd_lo;
    logic [7:0]  opnd_hi;
    logic [7:0]  rd_data;
    dec_op_t     dec;
    logic [7:0]  acc;
    logic [7:0]  alu_result;
    logic [7:0]  load_data;
    flags_t      flags;
    flags_t      flags_next;
    logic        cond_true;
    logic        rd_cyc;
    logic        wr_cyc;
    logic        in_t12;
    logic        last_cyc;
    logic        commit;

    // Reset release waits for a cen so the core starts on a clean step
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rst_sync <= 1'b0;
        end else if (cen) begin
            rst_sync <= 1'b1;
        end
    end

    // Next machine cycle, only looked at in T3
    always_comb begin
        next_mc  = MC_FETCH;
        last_cyc = 1'b1;
        case (mc)
            MC_FETCH: begin
                if (dec.n_opnd != 2'd0) begin
                    next_mc  = MC_OPND1;
                    last_cyc = 1'b0;
                end
            end
            MC_OPND1: begin
                if (dec.n_opnd == 2'd2) begin
                    next_mc  = MC_OPND2;
                    last_cyc = 1'b0;
                end
            end
            MC_OPND2: begin
                // nn is complete, loads and stores need one more cycle
                if (dec.kind == OP_LD_MEM) begin
                    next_mc  = MC_MEMRD;
                    last_cyc = 1'b0;
                end else if (dec.kind == OP_ST_MEM) begin
                    next_mc  = MC_MEMWR;
                    last_cyc = 1'b0;
                end
            end
            default: ;
        endcase
    end

    assign commit = cen && (ts == TS_T3) && last_cyc;

    // Bus cycle sequencer and PC
    always_ff @(posedge clk) begin
        if (!rst_sync) begin
            ts     <= TS_IDLE;
            mc     <= MC_FETCH;
            halted <= 1'b0;
            pc     <= RESET_PC;
        end else if (cen) begin
            case (ts)
                TS_IDLE: if (!halted) ts <= TS_T1;
                TS_T1:   ts <= TS_T2;
                TS_T2: begin
                    // Wait states repeat T2 with everything held
                    if (wait_n) begin
                        ts <= TS_T3;
                        if (mc == MC_FETCH || mc == MC_OPND1 || mc == MC_OPND2) begin
                            pc <= pc + 16'd1;
                        end
                    end
                end
                default: begin
                    mc <= next_mc;
                    ts <= TS_T1;
                    if (last_cyc && dec.kind == OP_HALT) begin
                        halted <= 1'b1;
                        ts     <= TS_IDLE;
                    end
                    if (last_cyc && dec.kind == OP_JUMP && cond_true) begin
                        pc <= {opnd_hi, opnd_lo};
                    end
                end
            endcase
        end
    end

    // Read data lands on the step leaving T2
    always_ff @(posedge clk) begin
        if (cen && ts == TS_T2 && wait_n) begin
            case (mc)
                MC_FETCH: opcode.raw <= din;
                MC_OPND1: opnd_lo    <= din;
                MC_OPND2: opnd_hi    <= din;
                MC_MEMRD: rd_data    <= din;
                default: ;
            endcase
        end
    end

    assign rd_cyc = (mc != MC_MEMWR);
    assign wr_cyc = (mc == MC_MEMWR);
    assign in_t12 = (ts == TS_T1) || (ts == TS_T2);

    // Reads strobe in T1 and T2, writes in T2 only
    always_comb begin
        bus.addr   = (mc == MC_MEMRD || mc == MC_MEMWR) ? {opnd_hi, opnd_lo} : pc;
        bus.dout   = acc;
        bus.m1_n   = !(mc == MC_FETCH && in_t12);
        bus.mreq_n = !(rd_cyc ? in_t12 : (ts == TS_T2));
        bus.rd_n   = !(rd_cyc && in_t12);
        bus.wr_n   = !(wr_cyc && ts == TS_T2);
    end

    assign halt_n    = !halted;
    // LD A,n takes the first operand, LD A,(nn) the memory byte
    assign load_data = (dec.kind == OP_LD_MEM) ? rd_data : opnd_lo;

    op_decode u_dec (
        .opcode ( opcode ),
        .op     ( dec    )
    );

    alu_execute u_alu (
        .op         ( dec        ),
        .acc        ( acc        ),
        .operand    ( opnd_lo    ),
        .flags      ( flags      ),
        .result     ( alu_result ),
        .flags_next ( flags_next ),
        .cond_true  ( cond_true  )
    );

    result_writeback u_wb (
        .clk        ( clk        ),
        .rst_n      ( rst_sync   ),
        .commit     ( commit     ),
        .op         ( dec        ),
        .result     ( alu_result ),
        .load_data  ( load_data  ),
        .flags_next ( flags_next ),
        .acc        ( acc        ),
        .flags      ( flags      )
    );

endmodule

// ==== src.f ====
source/bus_pkg.sv
source/isa_pkg.sv
source/rom_wait_gate.sv
source/op_decode.sv
source/alu_execute.sv
source/result_writeback.sv
source/work_ram.sv
source/z80_lite.sv
source/sysz80_top.sv
dv/sysz80_chk.sv
dv/tb_sysz80.sv
